//--- zap_pkg.sv
package zap_pkg;

        typedef struct packed {
                logic [3:0]  nzcv;      // Condition flags.
                logic [19:0] rsvd;
                logic        i;         // IRQ disable.
                logic        f;         // FIQ disable.
                logic        t;         // Thumb state.
                logic [4:0]  mode;
        } cpsr_t;

        typedef enum logic [4:0] {
                USR = 5'h10,
                FIQ = 5'h11,
                IRQ = 5'h12,
                SVC = 5'h13,
                ABT = 5'h17,
                UND = 5'h1B,
                SYS = 5'h1F
        } mode_t;

        typedef logic [5:0] phys_idx_t;

        localparam int CP_NUM_REGS = 16;

        typedef logic [$clog2(CP_NUM_REGS)-1:0] cp_idx_t;

        typedef struct packed {
                logic        dav;
                logic [31:0] word;
                phys_idx_t   reg_idx;
        } copro_req_t;

        typedef struct packed {
                logic [15:0] enable_mask;
                logic [3:0]  latency;
        } copro_cfg_t;

        // MRC, MCR, CDP, LDC and STC.
        function automatic logic is_copro_instr(input logic [31:0] word);
                return (word[27:24] == 4'b1110) || (word[27:25] == 3'b110);
        endfunction

        // MCR and MRC differ only in bit 20.
        function automatic logic is_reg_transfer(input logic [31:0] word);
                return (word[27:24] == 4'b1110) && word[4];
        endfunction

        // Architectural register plus mode to banked physical index.
        function automatic phys_idx_t translate(input logic [3:0] arch,
                                                input logic [4:0] mode);
                phys_idx_t idx;
                idx = phys_idx_t'(arch);
                if (arch >= 4'd8 && arch != 4'd15)
                begin
                        case (mode)
                        FIQ: idx = phys_idx_t'(arch) + 6'd8;
                        IRQ: if (arch >= 4'd13) idx = phys_idx_t'(arch) + 6'd10;
                        SVC: if (arch >= 4'd13) idx = phys_idx_t'(arch) + 6'd12;
                        ABT: if (arch >= 4'd13) idx = phys_idx_t'(arch) + 6'd14;
                        UND: if (arch >= 4'd13) idx = phys_idx_t'(arch) + 6'd16;
                        default: idx = phys_idx_t'(arch);   // USR and SYS.
                        endcase
                end
                return idx;
        endfunction

endpackage

//--- coproc_predecode.sv
`timescale 1ns/1ns

module coproc_predecode
        import zap_pkg::*;
#(
        parameter int PHY_REGS = 46
)
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_clear,        // Wins over stall.
        input  logic            i_stall,
        input  logic [31:0]     i_instruction,
        input  logic            i_valid,
        input  cpsr_t           i_cpsr,
        input  logic            i_irq,
        input  logic            i_fiq,
        input  logic            i_pipeline_busy,
        input  logic            i_copro_done,
        output logic [31:0]     o_instruction,
        output logic            o_valid,
        output logic            o_irq,
        output logic            o_fiq,
        output logic            o_stall_from_decode,
        output copro_req_t      o_copro_req
);

localparam int IDX_W = $clog2(PHY_REGS);

typedef enum logic {IDLE, BUSY} state_t;

state_t         state_ff;
state_t         state_nxt;
copro_req_t     req_nxt;
logic           trap;
logic [3:0]     arch_reg;
phys_idx_t      xlat_idx;

// Only ARM state instructions are trapped.
assign trap = i_valid && !i_cpsr.t && is_copro_instr(i_instruction);

always_comb
begin
        if (is_reg_transfer(i_instruction))
                arch_reg = i_instruction[15:12];        // Rd.
        else
                arch_reg = i_instruction[19:16];        // Rn.
        xlat_idx = translate(arch_reg, i_cpsr.mode);
end

always_comb
begin
        state_nxt           = state_ff;
        req_nxt             = o_copro_req;
        o_instruction       = 32'd0;
        o_valid             = 1'b0;
        o_irq               = 1'b0;
        o_fiq               = 1'b0;
        o_stall_from_decode = 1'b0;

        case (state_ff)
        IDLE:
        begin
                if (trap)
                begin
                        o_stall_from_decode = 1'b1;
                        if (i_pipeline_busy)
                        begin
                                req_nxt = '0;   // Let later stages drain.
                        end
                        else
                        begin
                                req_nxt.dav     = 1'b1;
                                req_nxt.word    = i_instruction;
                                req_nxt.reg_idx = phys_idx_t'(xlat_idx[IDX_W-1:0]);
                                state_nxt       = BUSY;
                        end
                end
                else
                begin
                        o_instruction = i_instruction;
                        o_valid       = i_valid;
                        o_irq         = i_irq;
                        o_fiq         = i_fiq;
                        req_nxt       = '0;
                end
        end
        BUSY:
        begin
                o_stall_from_decode = !i_copro_done;
                if (i_copro_done)
                begin
                        req_nxt   = '0;
                        state_nxt = IDLE;
                end
        end
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                state_ff    <= IDLE;
                o_copro_req <= '0;
        end
        else if (!i_stall)
        begin
                state_ff    <= state_nxt;
                o_copro_req <= req_nxt;
        end
end

endmodule

//--- coproc_engine.sv
`timescale 1ns/1ns

module coproc_engine
        import zap_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  copro_req_t      i_req,
        input  copro_cfg_t      i_cfg,
        input  logic [31:0]     i_cp_rdata,
        input  logic [31:0]     i_rf_rdata,
        output logic            o_done,
        output cp_idx_t         o_cp_rsel,
        output logic            o_cp_we,
        output cp_idx_t         o_cp_wsel,
        output logic [31:0]     o_cp_wdata,
        output phys_idx_t       o_rf_idx,
        output logic            o_rf_we,
        output logic [31:0]     o_rf_wdata,
        output logic            o_ev_done,
        output logic            o_ev_undef
);

typedef enum logic [1:0] {ENG_IDLE, ENG_RUN, ENG_DONE} eng_state_t;

eng_state_t     state_ff;
logic [3:0]     count_ff;
logic [31:0]    word_ff;
phys_idx_t      reg_ff;
logic [3:0]     cp_num;
cp_idx_t        crn;
logic           enabled;
logic           is_mcr;
logic           is_mrc;
logic           fire;

assign cp_num  = word_ff[11:8];
assign crn     = word_ff[19:16];
assign enabled = i_cfg.enable_mask[cp_num];
assign is_mcr  = is_reg_transfer(word_ff) && !word_ff[20];
assign is_mrc  = is_reg_transfer(word_ff) && word_ff[20];

// Last cycle of the latency count.
assign fire = (state_ff == ENG_RUN) && (count_ff == 4'd0) && i_req.dav;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_ff <= ENG_IDLE;
                count_ff <= 4'd0;
        end
        else
        begin
                case (state_ff)
                ENG_IDLE:
                begin
                        if (i_req.dav)
                        begin
                                state_ff <= ENG_RUN;
                                count_ff <= i_cfg.latency;
                        end
                end
                ENG_RUN:
                begin
                        if (!i_req.dav)
                                state_ff <= ENG_IDLE;   // Request flushed.
                        else if (count_ff == 4'd0)
                                state_ff <= ENG_DONE;
                        else
                                count_ff <= count_ff - 4'd1;
                end
                ENG_DONE:
                begin
                        // Done holds until the request is taken down.
                        if (!i_req.dav)
                                state_ff <= ENG_IDLE;
                end
                default:
                begin
                        state_ff <= ENG_IDLE;
                end
                endcase
        end
end

always_ff @(posedge i_clk)
begin
        if (state_ff == ENG_IDLE && i_req.dav)
        begin
                word_ff <= i_req.word;
                reg_ff  <= i_req.reg_idx;
        end
end

assign o_done     = (state_ff == ENG_DONE) && i_req.dav;
assign o_cp_rsel  = crn;
assign o_cp_wsel  = crn;
assign o_cp_wdata = i_rf_rdata;         // MCR source.
assign o_cp_we    = fire && enabled && is_mcr;
assign o_rf_idx   = reg_ff;
assign o_rf_wdata = i_cp_rdata;         // MRC source.
assign o_rf_we    = fire && enabled && is_mrc;
assign o_ev_done  = fire && enabled;
assign o_ev_undef = fire && !enabled;

endmodule

//--- coproc_regs_apb.sv
`timescale 1ns/1ns

module coproc_regs_apb
        import zap_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_psel,
        input  logic            i_penable,
        input  logic            i_pwrite,
        input  logic [7:0]      i_paddr,
        input  logic [31:0]     i_pwdata,
        input  cp_idx_t         i_cp_rsel,
        input  logic            i_cp_we,
        input  cp_idx_t         i_cp_wsel,
        input  logic [31:0]     i_cp_wdata,
        input  logic            i_ev_done,
        input  logic            i_ev_undef,
        output logic [31:0]     o_prdata,
        output logic            o_pready,
        output copro_cfg_t      o_cfg,
        output logic [31:0]     o_cp_rdata
);

localparam logic [7:0] ADDR_MASK  = 8'h40;
localparam logic [7:0] ADDR_LAT   = 8'h44;
localparam logic [7:0] ADDR_DONE  = 8'h48;
localparam logic [7:0] ADDR_UNDEF = 8'h4C;

logic [31:0]    cp_regs [CP_NUM_REGS];
logic [31:0]    done_cnt;
logic [31:0]    undef_cnt;
logic           apb_wr;
logic           apb_rd;
logic           cp_hit;
cp_idx_t        apb_sel;

assign apb_wr  = i_psel && i_penable && i_pwrite;       // Access edge.
assign apb_rd  = i_psel && !i_pwrite;
assign cp_hit  = (i_paddr[7:6] == 2'b00);
assign apb_sel = i_paddr[5:2];

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int k = 0; k < CP_NUM_REGS; k++)
                        cp_regs[k] <= 32'd0;
                o_cfg.enable_mask <= 16'hFFFF;
                o_cfg.latency     <= 4'd2;
                done_cnt          <= 32'd0;
                undef_cnt         <= 32'd0;
        end
        else
        begin
                if (apb_wr)
                begin
                        if (cp_hit)
                                cp_regs[apb_sel] <= i_pwdata;
                        else if (i_paddr == ADDR_MASK)
                                o_cfg.enable_mask <= i_pwdata[15:0];
                        else if (i_paddr == ADDR_LAT)
                                o_cfg.latency <= i_pwdata[3:0];
                end
                if (i_cp_we)
                        cp_regs[i_cp_wsel] <= i_cp_wdata;       // Engine has priority.
                if (i_ev_done)
                        done_cnt <= done_cnt + 32'd1;
                if (i_ev_undef)
                        undef_cnt <= undef_cnt + 32'd1;
        end
end

always_comb
begin
        o_prdata = 32'd0;
        if (apb_rd)
        begin
                if (cp_hit)
                begin
                        o_prdata = cp_regs[apb_sel];
                end
                else
                begin
                        case (i_paddr)
                        ADDR_MASK:  o_prdata = {16'd0, o_cfg.enable_mask};
                        ADDR_LAT:   o_prdata = {28'd0, o_cfg.latency};
                        ADDR_DONE:  o_prdata = done_cnt;
                        ADDR_UNDEF: o_prdata = undef_cnt;
                        default:    o_prdata = 32'd0;
                        endcase
                end
        end
end

assign o_pready   = 1'b1;               // No wait states.
assign o_cp_rdata = cp_regs[i_cp_rsel];

endmodule

//--- phys_regfile.sv
`timescale 1ns/1ns

module phys_regfile
        import zap_pkg::*;
#(
        parameter int PHY_REGS = 46
)
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_wb_en,
        input  phys_idx_t       i_wb_idx,
        input  logic [31:0]     i_wb_data,
        input  phys_idx_t       i_rd_idx,
        input  phys_idx_t       i_eng_idx,
        input  logic            i_eng_we,
        input  logic [31:0]     i_eng_wdata,
        output logic [31:0]     o_rd_data,
        output logic [31:0]     o_eng_rdata
);

logic [31:0] regs [PHY_REGS];

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int k = 0; k < PHY_REGS; k++)
                        regs[k] <= 32'd0;
        end
        else
        begin
                if (i_eng_we && i_eng_idx < PHY_REGS)
                        regs[i_eng_idx] <= i_eng_wdata;
                if (i_wb_en && i_wb_idx < PHY_REGS)
                        regs[i_wb_idx] <= i_wb_data;    // Writeback wins.
        end
end

// Out of range reads return zero.
assign o_rd_data   = (i_rd_idx < PHY_REGS) ? regs[i_rd_idx] : 32'd0;
assign o_eng_rdata = (i_eng_idx < PHY_REGS) ? regs[i_eng_idx] : 32'd0;

endmodule

//--- coproc_subsys_top.sv
`timescale 1ns/1ns

module coproc_subsys_top
        import zap_pkg::*;
#(
        parameter int PHY_REGS = 46
)
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic [31:0]     i_instruction,
        input  logic            i_valid,
        input  cpsr_t           i_cpsr,
        input  logic            i_irq,
        input  logic            i_fiq,
        input  logic            i_pipeline_busy,
        input  logic            i_clear,
        input  logic            i_stall,
        output logic [31:0]     o_instruction,
        output logic            o_valid,
        output logic            o_irq,
        output logic            o_fiq,
        output logic            o_stall_from_decode,
        input  logic            i_wb_en,
        input  phys_idx_t       i_wb_idx,
        input  logic [31:0]     i_wb_data,
        input  phys_idx_t       i_rd_idx,
        output logic [31:0]     o_rd_data,
        input  logic            i_psel,
        input  logic            i_penable,
        input  logic            i_pwrite,
        input  logic [7:0]      i_paddr,
        input  logic [31:0]     i_pwdata,
        output logic [31:0]     o_prdata,
        output logic            o_pready
);

copro_req_t     copro_req;
logic           copro_done;
copro_cfg_t     cfg;
logic [31:0]    cp_rdata;
cp_idx_t        cp_rsel;
logic           cp_we;
cp_idx_t        cp_wsel;
logic [31:0]    cp_wdata;
logic           ev_done;
logic           ev_undef;
phys_idx_t      rf_idx;
logic           rf_we;
logic [31:0]    rf_wdata;
logic [31:0]    rf_rdata;

coproc_predecode #(.PHY_REGS(PHY_REGS)) u_predecode (
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_clear             (i_clear),
        .i_stall             (i_stall),
        .i_instruction       (i_instruction),
        .i_valid             (i_valid),
        .i_cpsr              (i_cpsr),
        .i_irq               (i_irq),
        .i_fiq               (i_fiq),
        .i_pipeline_busy     (i_pipeline_busy),
        .i_copro_done        (copro_done),
        .o_instruction       (o_instruction),
        .o_valid             (o_valid),
        .o_irq               (o_irq),
        .o_fiq               (o_fiq),
        .o_stall_from_decode (o_stall_from_decode),
        .o_copro_req         (copro_req)
);

coproc_engine u_engine (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_req      (copro_req),
        .i_cfg      (cfg),
        .i_cp_rdata (cp_rdata),
        .i_rf_rdata (rf_rdata),
        .o_done     (copro_done),
        .o_cp_rsel  (cp_rsel),
        .o_cp_we    (cp_we),
        .o_cp_wsel  (cp_wsel),
        .o_cp_wdata (cp_wdata),
        .o_rf_idx   (rf_idx),
        .o_rf_we    (rf_we),
        .o_rf_wdata (rf_wdata),
        .o_ev_done  (ev_done),
        .o_ev_undef (ev_undef)
);

coproc_regs_apb u_regs (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .i_cp_rsel  (cp_rsel),
        .i_cp_we    (cp_we),
        .i_cp_wsel  (cp_wsel),
        .i_cp_wdata (cp_wdata),
        .i_ev_done  (ev_done),
        .i_ev_undef (ev_undef),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_cfg      (cfg),
        .o_cp_rdata (cp_rdata)
);

phys_regfile #(.PHY_REGS(PHY_REGS)) u_regfile (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_wb_en     (i_wb_en),
        .i_wb_idx    (i_wb_idx),
        .i_wb_data   (i_wb_data),
        .i_rd_idx    (i_rd_idx),
        .i_eng_idx   (rf_idx),
        .i_eng_we    (rf_we),
        .i_eng_wdata (rf_wdata),
        .o_rd_data   (o_rd_data),
        .o_eng_rdata (rf_rdata)
);

endmodule

//--- tb_coproc_ref.svh
`ifndef TB_COPROC_REF_SVH
`define TB_COPROC_REF_SVH

typedef struct packed {
        logic [31:0] word;
        logic        valid;
        logic        irq;
        logic        fiq;
        logic        stall;
} instr_obs_t;

typedef struct packed {
        logic      to_core;     // MRC lands in a core register.
        phys_idx_t idx;
} dest_t;

function automatic logic copro_pattern(input logic [31:0] w);
        return (w[27:24] == 4'b1110) || (w[27:25] == 3'b110);
endfunction

function automatic phys_idx_t ref_translate(input logic [3:0] r, input logic [4:0] m);
        int base;
        base = 0;
        if (r < 4'd8 || r == 4'd15)
                return phys_idx_t'(r);
        case (m)
        FIQ:     return phys_idx_t'(16 + r - 8);
        IRQ:     base = 23;
        SVC:     base = 25;
        ABT:     base = 27;
        UND:     base = 29;
        default: base = 0;
        endcase
        // r8 to r12 stay shared outside FIQ mode.
        if (base == 0 || r < 4'd13)
                return phys_idx_t'(r);
        return phys_idx_t'(base + r - 13);
endfunction

function automatic dest_t expected_dest(input logic [31:0] w, input logic [4:0] m);
        dest_t d;
        d.to_core = w[20];
        if (w[20])
                d.idx = ref_translate(w[15:12], m);
        else
                d.idx = phys_idx_t'(w[19:16]);  // CRn.
        return d;
endfunction

// Busy cycles, the capture cycle, the cycle dav is first seen and latency plus one count cycles.
function automatic int stall_cycles_ref(input int latency, input int busy);
        return busy + latency + 3;
endfunction

task automatic report_mismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first mismatch");
endtask

task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
                report_mismatch($sformatf("%s: got %08h, expected %08h", what, got, exp));
endtask

task automatic check_instr(input string what, input instr_obs_t got, input instr_obs_t exp);
        if (got !== exp)
                report_mismatch({$sformatf("%s: got %08h vifs=%b", what, got.word,
                                 {got.valid, got.irq, got.fiq, got.stall}),
                                 $sformatf(", expected %08h vifs=%b", exp.word,
                                 {exp.valid, exp.irq, exp.fiq, exp.stall})});
endtask

task automatic check_count(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
                report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
                report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
endtask

`endif

//--- tb_coproc_subsys.sv
`timescale 1ns/1ns

module tb_coproc_subsys
        import zap_pkg::*;
();

localparam int N_PASS     = 200;
localparam int N_OPS      = 30;
localparam int OP_CYCLES  = 60;         // Op plus the APB and register traffic around it.
localparam int MAX_CYCLES = 2 * (N_PASS + N_OPS * OP_CYCLES);
localparam logic [7:0] A_MASK  = 8'h40;
localparam logic [7:0] A_LAT   = 8'h44;
localparam logic [7:0] A_DONE  = 8'h48;
localparam logic [7:0] A_UNDEF = 8'h4C;

logic           i_clk = 1'b0;
logic           i_reset;
logic [31:0]    i_instruction;
logic           i_valid;
cpsr_t          i_cpsr;
logic           i_irq;
logic           i_fiq;
logic           i_pipeline_busy;
logic           i_clear;
logic           i_stall;
logic [31:0]    o_instruction;
logic           o_valid;
logic           o_irq;
logic           o_fiq;
logic           o_stall_from_decode;
logic           i_wb_en;
phys_idx_t      i_wb_idx;
logic [31:0]    i_wb_data;
phys_idx_t      i_rd_idx;
logic [31:0]    o_rd_data;
logic           i_psel;
logic           i_penable;
logic           i_pwrite;
logic [7:0]     i_paddr;
logic [31:0]    i_pwdata;
logic [31:0]    o_prdata;
logic           o_pready;

`include "tb_coproc_ref.svh"

logic [31:0]    exp_rf [64];
logic [31:0]    exp_cp [16];
int             exp_done = 0;
int             exp_undef = 0;
int             cur_latency = 2;
int             cycle_count = 0;
instr_obs_t     exp_q [$];
instr_obs_t     cmp_exp;
instr_obs_t     cmp_got;

coproc_subsys_top DUT (.*);

always #5 i_clk = ~i_clk;

always @(posedge i_clk)
begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
                $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
                $display("TEST FAILED");
                $fatal(1, "run stopped by the cycle limit");
        end
end

// Pass-through results are compared mid-cycle.
always @(negedge i_clk)
begin
        if (exp_q.size() > 0)
        begin
                cmp_exp = exp_q.pop_front();
                cmp_got = {o_instruction, o_valid, o_irq, o_fiq, o_stall_from_decode};
                check_instr("pass-through", cmp_got, cmp_exp);
        end
end

function automatic logic [4:0] mode_of(input int n);
        case (n)
        1:       return FIQ;
        2:       return IRQ;
        3:       return SVC;
        4:       return ABT;
        5:       return UND;
        6:       return SYS;
        default: return USR;
        endcase
endfunction

function automatic logic [31:0] xfer_word(input logic load, input logic [3:0] cp,
                                          input logic [3:0] crn, input logic [3:0] rd);
        return {4'hE, 4'b1110, 3'd0, load, crn, rd, cp, 3'd0, 1'b1, 4'd0};
endfunction

task automatic drive_passthrough(input logic [31:0] w, input logic v, input logic irq,
                                 input logic fiq, input cpsr_t cpsr);
        @(posedge i_clk);
        i_instruction <= w;
        i_valid       <= v;
        i_irq         <= irq;
        i_fiq         <= fiq;
        i_cpsr        <= cpsr;
        exp_q.push_back({w, v, irq, fiq, 1'b0});
endtask

task automatic wb_write(input phys_idx_t idx, input logic [31:0] data);
        @(posedge i_clk);
        i_wb_en   <= 1'b1;
        i_wb_idx  <= idx;
        i_wb_data <= data;
        @(posedge i_clk);
        i_wb_en   <= 1'b0;
        exp_rf[idx] = data;
endtask

task automatic rf_read(input phys_idx_t idx, output logic [31:0] data);
        @(posedge i_clk);
        i_rd_idx <= idx;
        @(negedge i_clk);
        data = o_rd_data;
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge i_clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b1;
        i_paddr   <= addr;
        i_pwdata  <= data;
        @(posedge i_clk);
        i_penable <= 1'b1;
        @(posedge i_clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge i_clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
        i_paddr   <= addr;
        @(posedge i_clk);
        i_penable <= 1'b1;
        @(negedge i_clk);
        data = o_prdata;
        @(posedge i_clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
endtask

// Holds a trapped word until the stall drops with the pipeline busy at first.
task automatic run_op(input logic [31:0] word, input logic [4:0] mode, input int busy);
        int    stall_n;
        cpsr_t cpsr;
        cpsr      = '0;
        cpsr.mode = mode;
        stall_n   = 0;
        @(posedge i_clk);
        i_instruction   <= word;
        i_valid         <= 1'b1;
        i_cpsr          <= cpsr;
        i_pipeline_busy <= (busy > 0);
        @(negedge i_clk);
        while (o_stall_from_decode)
        begin
                check_flag("valid during stall", o_valid, 1'b0);
                if (i_pipeline_busy)
                        check_flag("dav while pipeline busy", DUT.copro_req.dav, 1'b0);
                stall_n++;
                @(posedge i_clk);
                if (stall_n >= busy)
                        i_pipeline_busy <= 1'b0;
                @(negedge i_clk);
        end
        check_count("stall cycles", stall_n, stall_cycles_ref(cur_latency, busy));
        @(posedge i_clk);
        i_valid       <= 1'b0;
        i_instruction <= 32'd0;
        repeat (2) @(posedge i_clk);
endtask

// MCR from a random mode.
task automatic mcr_case(input int busy, input logic [3:0] cp, input logic enabled);
        logic [4:0]  mode;
        logic [3:0]  rd;
        logic [3:0]  crn;
        logic [31:0] word;
        logic [31:0] rdata;
        phys_idx_t   src;
        dest_t       dst;
        mode = mode_of($urandom % 7);
        rd   = 4'($urandom % 16);
        crn  = 4'($urandom % 16);
        src  = ref_translate(rd, mode);
        wb_write(src, $urandom);
        wb_write(phys_idx_t'($urandom % 46), $urandom);
        word = xfer_word(1'b0, cp, crn, rd);
        run_op(word, mode, busy);
        dst = expected_dest(word, mode);
        if (enabled)
        begin
                exp_cp[dst.idx[3:0]] = exp_rf[src];
                exp_done++;
        end
        else
                exp_undef++;
        apb_read({2'b00, crn, 2'b00}, rdata);
        check_word("coprocessor register after MCR", rdata, exp_cp[crn]);
endtask

task automatic mrc_case(input logic [3:0] cp, input logic enabled);
        logic [4:0]  mode;
        logic [3:0]  rd;
        logic [3:0]  crn;
        logic [31:0] word;
        logic [31:0] rdata;
        dest_t       dst;
        mode = mode_of(1 + $urandom % 5);       // Banked modes only.
        rd   = 4'(13 + $urandom % 2);
        crn  = 4'($urandom % 16);
        wb_write(ref_translate(rd, USR), $urandom);
        exp_cp[crn] = $urandom;
        apb_write({2'b00, crn, 2'b00}, exp_cp[crn]);
        word = xfer_word(1'b1, cp, crn, rd);
        run_op(word, mode, 0);
        dst = expected_dest(word, mode);
        if (enabled)
        begin
                exp_rf[dst.idx] = exp_cp[crn];
                exp_done++;
        end
        else
                exp_undef++;
        rf_read(dst.idx, rdata);
        check_word("core register after MRC", rdata, exp_rf[dst.idx]);
        rf_read(ref_translate(rd, USR), rdata);
        check_word("user bank register", rdata, exp_rf[ref_translate(rd, USR)]);
endtask

initial
begin
        logic [31:0] w;
        logic [31:0] rdata;
        logic [3:0]  cp;
        cpsr_t       cpsr;
        void'($urandom(7));
        for (int k = 0; k < 64; k++)
                exp_rf[k] = 32'd0;
        for (int k = 0; k < 16; k++)
                exp_cp[k] = 32'd0;
        i_reset         = 1'b1;
        i_instruction   = 32'd0;
        i_valid         = 1'b0;
        i_cpsr          = '0;
        i_irq           = 1'b0;
        i_fiq           = 1'b0;
        i_pipeline_busy = 1'b0;
        i_clear         = 1'b0;
        i_stall         = 1'b0;
        i_wb_en         = 1'b0;
        i_wb_idx        = '0;
        i_wb_data       = 32'd0;
        i_rd_idx        = '0;
        i_psel          = 1'b0;
        i_penable       = 1'b0;
        i_pwrite        = 1'b0;
        i_paddr         = 8'd0;
        i_pwdata        = 32'd0;
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;

        @(negedge i_clk);
        check_flag("dav after reset", DUT.copro_req.dav, 1'b0);
        check_flag("stall after reset", o_stall_from_decode, 1'b0);
        check_flag("pready", o_pready, 1'b1);
        apb_read(A_MASK, rdata);
        check_word("enable mask after reset", rdata, 32'h0000_FFFF);
        apb_read(A_LAT, rdata);
        check_word("latency after reset", rdata, 32'd2);

        repeat (N_PASS)
        begin
                do
                        w = $urandom;
                while (copro_pattern(w));
                cpsr      = '0;
                cpsr.mode = mode_of($urandom % 7);
                cpsr.t    = 1'($urandom % 2);
                drive_passthrough(w, 1'($urandom % 2), 1'($urandom % 2), 1'($urandom % 2), cpsr);
        end
        drive_passthrough(32'd0, 1'b0, 1'b0, 1'b0, '0);
        while (exp_q.size() != 0)
                @(posedge i_clk);

        repeat (10) mcr_case(0, 4'($urandom % 16), 1'b1);
        repeat (10) mrc_case(4'($urandom % 16), 1'b1);

        apb_write(A_LAT, 32'd5);
        cur_latency = 5;
        mcr_case(4, 4'd2, 1'b1);
        mcr_case(0, 4'd3, 1'b1);

        // With the T bit set the word is an ordinary instruction.
        cpsr   = '0;
        cpsr.t = 1'b1;
        drive_passthrough(xfer_word(1'b0, 4'd5, 4'd6, 4'd1), 1'b1, 1'b0, 1'b0, cpsr);
        drive_passthrough(32'd0, 1'b0, 1'b0, 1'b0, '0);
        while (exp_q.size() != 0)
                @(posedge i_clk);

        cp = 4'($urandom % 16);
        apb_write(A_MASK, 32'h0000_FFFF & ~(32'd1 << cp));
        mcr_case(0, cp, 1'b0);
        mrc_case(cp, 1'b0);
        apb_write(A_MASK, 32'h0000_FFFF);

        run_op({4'hE, 4'b1110, 4'd0, 4'd4, 4'd5, 4'd6, 3'd0, 1'b0, 4'd0}, USR, 0);    // CDP.
        exp_done++;
        run_op({4'hE, 3'b110, 5'b11001, 4'd9, 4'd2, 4'd7, 8'd0}, SVC, 0);             // LDC.
        exp_done++;

        // Clear while the engine counts and before any write.
        wb_write(phys_idx_t'(3), ~exp_cp[7]);
        @(posedge i_clk);
        i_instruction <= xfer_word(1'b0, 4'd1, 4'd7, 4'd3);
        i_valid       <= 1'b1;
        i_cpsr        <= '0;
        do
                @(negedge i_clk);
        while (!DUT.copro_req.dav);
        @(posedge i_clk);
        i_clear <= 1'b1;
        @(posedge i_clk);
        i_clear       <= 1'b0;
        i_valid       <= 1'b0;
        i_instruction <= 32'd0;
        @(negedge i_clk);
        check_flag("stall after clear", o_stall_from_decode, 1'b0);
        check_flag("dav after clear", DUT.copro_req.dav, 1'b0);
        repeat (cur_latency + 4) @(posedge i_clk);
        apb_read({2'b00, 4'd7, 2'b00}, rdata);
        check_word("register after cleared MCR", rdata, exp_cp[7]);

        apb_read(A_DONE, rdata);
        check_count("completed operations", rdata, exp_done);
        apb_read(A_UNDEF, rdata);
        check_count("undefined operations", rdata, exp_undef);
        $display("TEST PASSED");
        $finish;
end

endmodule

//--- all.f
+incdir+.
zap_pkg.sv
coproc_predecode.sv
coproc_engine.sv
coproc_regs_apb.sv
phys_regfile.sv
coproc_subsys_top.sv
tb_coproc_subsys.sv

//--- Bender.yml
package:
  name: coproc_subsys

sources:
  - zap_pkg.sv
  - coproc_predecode.sv
  - coproc_engine.sv
  - coproc_regs_apb.sv
  - phys_regfile.sv
  - coproc_subsys_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_coproc_subsys.sv
